// File: compile.f
+incdir+hw
hw/bist_pkg.sv
hw/dual_clock_ram.sv
hw/req_ack_sync.sv
hw/pattern_writer.sv
hw/pattern_checker.sv
hw/ram_selftest_top.sv
testbench/tb_ram_selftest.sv

// File: hw/bist_defs.svh
`ifndef BIST_DEFS_SVH
`define BIST_DEFS_SVH

// Frame buffer word width in bits
`define DATA_W 16

// Frame buffer address width in bits
`define ADDR_W 8

// Number of words in the frame buffer
`define RAM_DEPTH 256

// Flip-flops in each clock domain crossing chain
`define SYNC_STAGES 2

`endif

// File: hw/bist_pkg.sv
`include "bist_defs.svh"

package bist_pkg;

    typedef logic [`DATA_W-1:0] word_t;
    typedef logic [`ADDR_W-1:0] addr_t;

    // One extra bit so a full-RAM mismatch count fits
    typedef logic [`ADDR_W:0] count_t;

    typedef enum logic [1:0] {
        w_idle,
        w_fill,
        w_done
    } fill_state_t;

    typedef enum logic [2:0] {
        c_idle,
        c_fill_req,
        c_fill_wait,
        c_sweep,
        c_drain,
        c_report
    } check_state_t;

endpackage

// File: hw/dual_clock_ram.sv
`include "bist_defs.svh"

module dual_clock_ram (
    input  logic            rgb_clk,
    input  logic            wr_en,
    input  bist_pkg::addr_t wr_addr,
    input  bist_pkg::word_t wr_data,
    input  logic            clk,
    input  bist_pkg::addr_t rd_addr,
    output bist_pkg::word_t rd_data
);
    import bist_pkg::*;

    word_t mem [`RAM_DEPTH];

    // Write side runs on the video clock
    always_ff @(posedge rgb_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read with one clk of latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

    // Writes need a known address inside the configured depth
    a_wr_addr_range: assert property (
        @(posedge rgb_clk) wr_en |-> (!$isunknown(wr_addr) && (int'(wr_addr) < `RAM_DEPTH))
    ) else $error("RAM write to unknown or out of range address %0d", wr_addr);

endmodule

// File: hw/pattern_checker.sv
`include "bist_defs.svh"

module pattern_checker (
    input  logic             clk,
    input  logic             nrst,
    input  logic             test_req,
    input  logic             check_only,
    input  bist_pkg::word_t  seed,
    output logic             test_ack,
    output logic             test_pass,
    output bist_pkg::count_t err_count,
    output bist_pkg::addr_t  fail_addr,
    output logic             fill_req,
    input  logic             fill_done,
    output bist_pkg::word_t  seed_hold,
    output bist_pkg::addr_t  rd_addr,
    input  bist_pkg::word_t  rd_data
);
    import bist_pkg::*;

    check_state_t state;
    addr_t        cmp_addr;
    logic         cmp_valid;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state     <= c_idle;
            test_ack  <= 1'b0;
            test_pass <= 1'b0;
            err_count <= '0;
            fail_addr <= '0;
            fill_req  <= 1'b0;
            rd_addr   <= '0;
            cmp_valid <= 1'b0;
        end else begin
            cmp_valid <= 1'b0;
            case (state)
                c_idle: begin
                    if (test_req) begin
                        err_count <= '0;
                        fail_addr <= '0;
                        test_pass <= 1'b0;
                        rd_addr   <= '0;
                        state     <= check_only ? c_sweep : c_fill_req;
                    end
                end
                c_fill_req: begin
                    // Seed has been stable for a cycle before the request goes up
                    fill_req <= 1'b1;
                    if (fill_done) begin
                        fill_req <= 1'b0;
                        state    <= c_fill_wait;
                    end
                end
                c_fill_wait: begin
                    if (!fill_done) begin
                        state <= c_sweep;
                    end
                end
                c_sweep: begin
                    cmp_addr  <= rd_addr;
                    cmp_valid <= 1'b1;
                    rd_addr   <= rd_addr + 1'b1;
                    if (rd_addr == addr_t'(`RAM_DEPTH - 1)) begin
                        state <= c_drain;
                    end
                end
                c_drain: begin
                    state <= c_report;
                end
                c_report: begin
                    if (test_req) begin
                        test_ack  <= 1'b1;
                        test_pass <= (err_count == '0);
                    end else begin
                        test_ack <= 1'b0;
                        state    <= c_idle;
                    end
                end
                default: begin
                    state <= c_idle;
                end
            endcase

            // Read data lags the issued address by one cycle
            if (cmp_valid && (rd_data != (seed_hold ^ word_t'(cmp_addr)))) begin
                err_count <= err_count + 1'b1;
                if (err_count == '0) begin
                    fail_addr <= cmp_addr;
                end
            end
        end
    end

    // Seed latch for the pattern on both sides
    always_ff @(posedge clk) begin
        if (state == c_idle && test_req) begin
            seed_hold <= seed;
        end
    end

    // Host must keep the request up for the whole test
    a_req_during_test: assert property (
        @(posedge clk) disable iff (!nrst)
        (state != c_idle && state != c_report) |-> test_req
    ) else $error("test_req dropped while a test was running");

endmodule

// File: hw/pattern_writer.sv
`include "bist_defs.svh"

module pattern_writer (
    input  logic            rgb_clk,
    input  logic            nrst,
    input  logic            pix_we,
    input  bist_pkg::addr_t pix_addr,
    input  bist_pkg::word_t pix_data,
    input  logic            fill_req,
    input  bist_pkg::word_t seed,
    output logic            fill_done,
    output logic            wr_en,
    output bist_pkg::addr_t wr_addr,
    output bist_pkg::word_t wr_data
);
    import bist_pkg::*;

    fill_state_t state;
    addr_t       fill_addr;

    always_ff @(posedge rgb_clk or negedge nrst) begin
        if (!nrst) begin
            state     <= w_idle;
            fill_addr <= '0;
            fill_done <= 1'b0;
            wr_en     <= 1'b0;
        end else begin
            case (state)
                w_idle: begin
                    // Pixel port owns the RAM while idle
                    wr_en <= pix_we;
                    if (fill_req) begin
                        fill_addr <= '0;
                        state     <= w_fill;
                    end
                end
                w_fill: begin
                    wr_en     <= 1'b1;
                    fill_addr <= fill_addr + 1'b1;
                    if (fill_addr == addr_t'(`RAM_DEPTH - 1)) begin
                        state <= w_done;
                    end
                end
                w_done: begin
                    wr_en <= 1'b0;
                    // Hold done until the request is seen low
                    if (!fill_req) begin
                        fill_done <= 1'b0;
                        state     <= w_idle;
                    end else begin
                        fill_done <= 1'b1;
                    end
                end
                default: begin
                    state <= w_idle;
                end
            endcase
        end
    end

    // Write payload, fill pattern overrides the pixel port
    always_ff @(posedge rgb_clk) begin
        if (state == w_fill) begin
            wr_addr <= fill_addr;
            wr_data <= seed ^ word_t'(fill_addr);
        end else begin
            wr_addr <= pix_addr;
            wr_data <= pix_data;
        end
    end

endmodule

// File: hw/ram_selftest_top.sv
module ram_selftest_top (
    input  logic             clk,
    input  logic             rgb_clk,
    input  logic             nrst,
    input  logic             pix_we,
    input  bist_pkg::addr_t  pix_addr,
    input  bist_pkg::word_t  pix_data,
    input  logic             test_req,
    output logic             test_ack,
    input  logic             check_only,
    input  bist_pkg::word_t  seed,
    output logic             test_pass,
    output bist_pkg::count_t err_count,
    output bist_pkg::addr_t  fail_addr
);
    import bist_pkg::*;

    // RAM ports
    logic  wr_en;
    addr_t wr_addr;
    word_t wr_data;
    addr_t rd_addr;
    word_t rd_data;

    // Fill handshake on both sides of the crossing
    logic  fill_req;
    logic  fill_req_rgb;
    logic  fill_done_rgb;
    logic  fill_done;
    word_t seed_hold;

    dual_clock_ram i_dual_clock_ram (
        .rgb_clk (rgb_clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .clk     (clk),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    req_ack_sync i_req_ack_sync (
        .clk     (clk),
        .rgb_clk (rgb_clk),
        .nrst    (nrst),
        .req_src (fill_req),
        .req_dst (fill_req_rgb),
        .ack_dst (fill_done_rgb),
        .ack_src (fill_done)
    );

    pattern_writer i_pattern_writer (
        .rgb_clk   (rgb_clk),
        .nrst      (nrst),
        .pix_we    (pix_we),
        .pix_addr  (pix_addr),
        .pix_data  (pix_data),
        .fill_req  (fill_req_rgb),
        .seed      (seed_hold),
        .fill_done (fill_done_rgb),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data)
    );

    pattern_checker i_pattern_checker (
        .clk        (clk),
        .nrst       (nrst),
        .test_req   (test_req),
        .check_only (check_only),
        .seed       (seed),
        .test_ack   (test_ack),
        .test_pass  (test_pass),
        .err_count  (err_count),
        .fail_addr  (fail_addr),
        .fill_req   (fill_req),
        .fill_done  (fill_done),
        .seed_hold  (seed_hold),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data)
    );

endmodule

// File: hw/req_ack_sync.sv
`include "bist_defs.svh"

module req_ack_sync (
    input  logic clk,
    input  logic rgb_clk,
    input  logic nrst,
    input  logic req_src,
    output logic req_dst,
    input  logic ack_dst,
    output logic ack_src
);

    logic [`SYNC_STAGES-1:0] req_chain;
    logic [`SYNC_STAGES-1:0] ack_chain;

    // Request into the video clock domain
    always_ff @(posedge rgb_clk or negedge nrst) begin
        if (!nrst) begin
            req_chain <= '0;
        end else begin
            req_chain <= {req_chain[`SYNC_STAGES-2:0], req_src};
        end
    end

    // Acknowledge back into the system clock domain
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            ack_chain <= '0;
        end else begin
            ack_chain <= {ack_chain[`SYNC_STAGES-2:0], ack_dst};
        end
    end

    assign req_dst = req_chain[`SYNC_STAGES-1];
    assign ack_src = ack_chain[`SYNC_STAGES-1];

    // Source keeps the request up until the acknowledge has come back
    a_req_held: assert property (
        @(posedge clk) disable iff (!nrst) $fell(req_src) |-> ack_src
    ) else $error("fill request dropped before acknowledge");

    // Destination keeps the acknowledge up until the request is gone
    a_ack_held: assert property (
        @(posedge rgb_clk) disable iff (!nrst) $fell(ack_dst) |-> !req_dst
    ) else $error("fill acknowledge dropped while request still high");

endmodule

// File: testbench/tb_ram_selftest.sv
`include "bist_defs.svh"

module tb_ram_selftest;
    import bist_pkg::*;

    localparam int NUM_ROWS = 6;
    localparam int TIMEOUT_CYCLES = 4000;

    logic   clk;
    logic   rgb_clk;
    logic   nrst;
    logic   pix_we;
    addr_t  pix_addr;
    word_t  pix_data;
    logic   test_req;
    logic   test_ack;
    logic   check_only;
    word_t  seed;
    logic   test_pass;
    count_t err_count;
    addr_t  fail_addr;

    // Scenario table, one column per array
    logic   row_check_only [NUM_ROWS];
    word_t  row_seed       [NUM_ROWS];
    logic   row_preload    [NUM_ROWS];
    word_t  row_pre_seed   [NUM_ROWS];
    int     row_n_corrupt  [NUM_ROWS];
    addr_t  row_corrupt    [NUM_ROWS][2];
    logic   row_exp_pass   [NUM_ROWS];
    count_t row_exp_count  [NUM_ROWS];
    addr_t  row_exp_addr   [NUM_ROWS];
    int     row_hold       [NUM_ROWS];

    int          cur_row;
    int unsigned seed_draw;

    ram_selftest_top i_ram_selftest_top (
        .clk        (clk),
        .rgb_clk    (rgb_clk),
        .nrst       (nrst),
        .pix_we     (pix_we),
        .pix_addr   (pix_addr),
        .pix_data   (pix_data),
        .test_req   (test_req),
        .test_ack   (test_ack),
        .check_only (check_only),
        .seed       (seed),
        .test_pass  (test_pass),
        .err_count  (err_count),
        .fail_addr  (fail_addr)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Video clock, unrelated to clk
    initial begin
        rgb_clk = 1'b0;
        forever #35 rgb_clk = ~rgb_clk;
    end

    // Expected word: seed XOR zero-extended address
    function automatic word_t pattern_word(word_t s, addr_t a);
        return s ^ word_t'(a);
    endfunction

    task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] time %0t row %0d %s: got 0x%0h, expected 0x%0h",
                     $time, cur_row, name, actual, expected);
            $display("Regression failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic wait_for_ack(logic level, string what);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (test_ack !== level && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (test_ack !== level) begin
            $display("Timeout: %s did not happen within %0d clk cycles", what, TIMEOUT_CYCLES);
            $display("Regression failed");
            $fatal(1, "wait timed out");
        end
    endtask

    task automatic set_row(int r, logic co, word_t s, logic pre, word_t pre_s, int n,
                           addr_t c0, addr_t c1, int exp_cnt, addr_t exp_addr, int hold);
        row_check_only[r] = co;
        row_seed[r]       = s;
        row_preload[r]    = pre;
        row_pre_seed[r]   = pre_s;
        row_n_corrupt[r]  = n;
        row_corrupt[r][0] = c0;
        row_corrupt[r][1] = c1;
        row_exp_count[r]  = count_t'(exp_cnt);
        row_exp_pass[r]   = (exp_cnt == 0);
        row_exp_addr[r]   = exp_addr;
        row_hold[r]       = hold;
    endtask

    task automatic build_table();
        word_t s_fill;
        word_t s_one;
        word_t s_two;
        word_t s_refill;
        addr_t a0;
        addr_t a1;
        addr_t a2;
        s_fill   = word_t'($urandom);
        s_one    = word_t'($urandom);
        s_two    = word_t'($urandom);
        s_refill = word_t'($urandom);
        a0 = addr_t'($urandom % `RAM_DEPTH);
        a1 = addr_t'($urandom % `RAM_DEPTH);
        // Offset of 1 to 255 keeps the second address distinct
        a2 = addr_t'(a1 + 1 + ($urandom % (`RAM_DEPTH - 1)));
        // Fill over inverted contents, then retention with the same seed
        set_row(0, 1'b0, s_fill, 1'b1, ~s_fill, 0, '0, '0, 0, '0, 0);
        set_row(1, 1'b1, s_fill, 1'b0, '0, 0, '0, '0, 0, '0, 0);
        // Wrong seed, every word differs; host holds the request
        set_row(2, 1'b1, s_fill ^ 16'h8000, 1'b0, '0, 0, '0, '0, `RAM_DEPTH, '0, 20);
        set_row(3, 1'b1, s_one, 1'b1, s_one, 1, a0, '0, 1, a0, 0);
        set_row(4, 1'b1, s_two, 1'b1, s_two, 2, a1, a2, 2, (a1 < a2) ? a1 : a2, 0);
        set_row(5, 1'b0, s_refill, 1'b0, '0, 0, '0, '0, 0, '0, 0);
    endtask

    task automatic preload_pixels(int r);
        word_t w;
        for (int a = 0; a < `RAM_DEPTH; a++) begin
            w = pattern_word(row_pre_seed[r], addr_t'(a));
            for (int k = 0; k < row_n_corrupt[r]; k++) begin
                if (row_corrupt[r][k] == addr_t'(a)) begin
                    w = w ^ word_t'(16'h0001);
                end
            end
            @(posedge rgb_clk);
            pix_we   <= 1'b1;
            pix_addr <= addr_t'(a);
            pix_data <= w;
        end
        @(posedge rgb_clk);
        pix_we <= 1'b0;
        // Writer registers the port, last word lands one edge later
        repeat (2) @(posedge rgb_clk);
    endtask

    task automatic check_results(int r);
        check_value("test_pass", test_pass, row_exp_pass[r]);
        check_value("err_count", err_count, row_exp_count[r]);
        check_value("fail_addr", fail_addr, row_exp_addr[r]);
    endtask

    task automatic run_row(int r);
        cur_row = r;
        if (row_preload[r]) begin
            preload_pixels(r);
        end
        @(posedge clk);
        check_only <= row_check_only[r];
        seed       <= row_seed[r];
        test_req   <= 1'b1;
        wait_for_ack(1'b1, "test_ack rising after test_req");
        check_results(r);
        // Results must hold while the host keeps the request up
        for (int k = 0; k < row_hold[r]; k++) begin
            @(negedge clk);
            check_value("test_ack", test_ack, 1'b1);
            check_results(r);
        end
        @(posedge clk);
        test_req <= 1'b0;
        wait_for_ack(1'b0, "test_ack falling after test_req dropped");
        check_results(r);
    endtask

    initial begin
        nrst       = 1'b0;
        pix_we     = 1'b0;
        pix_addr   = '0;
        pix_data   = '0;
        test_req   = 1'b0;
        check_only = 1'b0;
        seed       = '0;
        cur_row    = -1;
        seed_draw  = $urandom(32'hb8093423);
        build_table();
        repeat (2) @(posedge clk);
        nrst <= 1'b1;
        @(negedge clk);
        // Idle outputs straight after reset
        check_value("test_ack", test_ack, 1'b0);
        check_value("test_pass", test_pass, 1'b0);
        check_value("err_count", err_count, '0);
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        $display("Regression passed");
        $finish;
    end

endmodule
